//--- verilog.f
+incdir+bench
verilog/parser_pkg.sv
verilog/number_accum.sv
verilog/keyword_matcher.sv
verilog/stmt_parser_fsm.sv
verilog/cond_eval.sv
verilog/if_else_parser.sv
bench/tb_if_else_parser.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the parser testbench with Verilator, then search the log

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_if_else_parser \
    -f verilog.f -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }

# An abnormal simulator exit counts as a failure
./obj_dir/sim_tb > sim.log 2>&1 || echo "ERRORS FOUND" >> sim.log
cat sim.log

grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0

//--- bench/tb_stream_tasks.svh
`ifndef TB_STREAM_TASKS_SVH
`define TB_STREAM_TASKS_SVH

// Statement text without whitespace as the parser expects it
function automatic string build_stmt(input string op, input int valc, input string a1,
                                     input int c1, input string a2, input int c2);
    return $sformatf("if(x%s%0d)beginp%s%0d;endelsebeginp%s%0d;end",
                     op, valc, a1, c1, a2, c2);
endfunction

// Result of the conditional assignment for a given x
function automatic value_t expected_p(input string op, input int xv, input int valc,
                                      input int c1, input int c2);
    logic hit;
    if (op == "==")
        hit = (xv == valc);
    else if (op == "!=")
        hit = (xv != valc);
    else if (op == "<")
        hit = (xv < valc);
    else if (op == ">")
        hit = (xv > valc);
    else if (op == "<=")
        hit = (xv <= valc);
    else
        hit = (xv >= valc);
    return hit ? value_t'(c1) : value_t'(c2);
endfunction

// One character per valid cycle with up to max_gap idle cycles between
task automatic send_stmt(input string s, input int max_gap);
    byte c;
    int  gap;
    for (int i = 0; i < s.len(); i++) begin
        c = s[i];
        @(posedge clk);
        char       <= c[6:0];
        char_valid <= 1'b1;
        if (i < s.len() - 1) begin             // No gap after the final d
            gap = (max_gap > 0) ? $unsigned($random(seed)) % (max_gap + 1) : 0;
            repeat (gap) begin
                @(posedge clk);
                char_valid <= 1'b0;
            end
        end
    end
endtask

task automatic valid_case(input string name, input string op, input string a1,
                          input string a2, input int max_gap, input int xv,
                          input int valc, input int c1, input int c2);
    run_case(name, build_stmt(op, valc, a1, c1, a2, c2), max_gap, xv,
             expected_p(op, xv, valc, c1, c2), 1'b1, ERR_NONE);
endtask

// x sits at a chosen offset from a random valc so each relation can be reached
task automatic random_case(input string name, input string op, input string a1,
                           input string a2, input int max_gap, input int offset);
    int valc;
    int c1;
    int c2;
    valc = $random(seed) % 50;
    c1   = $random(seed) % 100;
    c2   = $random(seed) % 100;
    if (c2 == c1)
        c2 = c1 + 1;                           // Branches must give different results
    valid_case(name, op, a1, a2, max_gap, valc + offset, valc, c1, c2);
endtask

`endif

//--- bench/tb_if_else_parser.sv
`timescale 1ns/10ps
`default_nettype none

module tb_if_else_parser import parser_pkg::*; ();

    localparam int  NUM_STMTS = 34;
    localparam int  MAX_LEN   = 50;               // Longest statement in characters
    localparam int  MAX_GAP   = 3;
    localparam int  RST_CYC   = 8;
    localparam int  MARGIN    = 10;
    localparam real WATCHDOG_NS =
        NUM_STMTS * (MAX_LEN * (MAX_GAP + 1) + RST_CYC + MARGIN) * 100.0;

    logic        clk = 1'b0;
    logic        rst;
    char_t       char;
    logic        char_valid;
    value_t      x;
    value_t      p;
    logic        parsing_done;
    logic        error_flag;
    error_code_t error_code;

    int          seed = 88459;
    int          value_errors = 0;
    int          status_errors = 0;
    logic        check_en;                        // One-cycle check window
    string       test_name;
    value_t      exp_p;
    logic        exp_done;
    error_code_t exp_code;

    always #50 clk = ~clk;

    if_else_parser dut0 (
        .clk          (clk),
        .rst          (rst),
        .char         (char),
        .char_valid   (char_valid),
        .x            (x),
        .p            (p),
        .parsing_done (parsing_done),
        .error_flag   (error_flag),
        .error_code   (error_code)
    );

    a_result : assert property (@(posedge clk) check_en |-> p == exp_p)
        else begin
            value_errors = value_errors + 1;
            $display("ERROR %s: p expected %0d actual %0d", test_name, exp_p, p);
        end

    a_done : assert property (@(posedge clk) check_en |-> parsing_done == exp_done)
        else begin
            status_errors = status_errors + 1;
            $display("ERROR %s: parsing_done expected %0d actual %0d",
                     test_name, exp_done, parsing_done);
        end

    a_code : assert property (@(posedge clk) check_en |-> error_code == exp_code)
        else begin
            status_errors = status_errors + 1;
            $display("ERROR %s: error_code expected %0d actual %0d",
                     test_name, exp_code, error_code);
        end

    a_flag : assert property (@(posedge clk)
                              check_en |-> error_flag == (exp_code != ERR_NONE))
        else begin
            status_errors = status_errors + 1;
            $display("ERROR %s: error_flag expected %0d actual %0d",
                     test_name, exp_code != ERR_NONE, error_flag);
        end

    task automatic apply_reset();
        @(posedge clk);
        rst        <= 1'b1;
        char_valid <= 1'b0;
        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_case(input string name, input string s, input int max_gap,
                            input int xv, input value_t p_ok, input logic done_ok,
                            input error_code_t code_ok);
        apply_reset();
        test_name <= name;
        x         <= xv;                          // Held until the result is in
        exp_p     <= p_ok;
        exp_done  <= done_ok;
        exp_code  <= code_ok;
        send_stmt(s, max_gap);
        @(posedge clk);
        char_valid <= 1'b0;                       // Final d sampled at this edge
        @(posedge clk);
        check_en <= 1'b1;
        @(posedge clk);
        check_en <= 1'b0;                         // Window is sampled two edges after the d
    endtask

    `include "tb_stream_tasks.svh"

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequence finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        string ops[6];
        ops        = '{"==", "!=", "<", ">", "<=", ">="};
        rst        = 1'b1;
        char       = '0;
        char_valid = 1'b0;
        x          = '0;
        check_en   = 1'b0;

        // x below, on and above valc for every comparator
        foreach (ops[i]) begin
            for (int off = -1; off <= 1; off++)
                random_case($sformatf("cmp %s off %0d", ops[i], off), ops[i], "<=", "<=",
                            0, off);
        end

        // Negative constants and the digit right after < or >
        valid_case("neg lt shortcut", "<", "<=", "<=", 0, -9, -7, -12, -3);
        valid_case("gt shortcut", ">", "<=", "<=", 0, 6, 5, 40, -40);
        valid_case("neg gt false", ">", "<=", "<=", 0, -20, -20, -1, -99);
        valid_case("neg le", "<=", "<=", "<=", 0, -1, -1, -512, 77);

        // Mixed spellings with idle cycles between characters
        random_case("assign = <=", ">=", "=", "<=", MAX_GAP, 1);
        random_case("assign <= =", "!=", "<=", "=", MAX_GAP, 0);
        random_case("assign = =", "<", "=", "=", MAX_GAP, -1);

        run_case("kw iff", "iff(x==1)beginp<=1;endelsebeginp<=2;end",
                 0, 0, 0, 1'b0, ERR_INVALID_KEYWORD);
        run_case("kw begn", "if(x==1)begnp<=1;endelsebeginp<=2;end",
                 0, 0, 0, 1'b0, ERR_INVALID_KEYWORD);
        run_case("kw els", "if(x==1)beginp<=1;endelsbeginp<=2;end",
                 0, 0, 0, 1'b0, ERR_INVALID_KEYWORD);
        run_case("var mismatch", "if(x==1)beginp<=1;endelsebeginq<=2;end",
                 0, 0, 0, 1'b0, ERR_VAR_MISMATCH);

        // Trailing characters after each error must leave the code alone
        run_case("bad operator", "if(x?1)beginp<=1;endelsebeginp<=2;end",
                 0, 0, 0, 1'b0, ERR_INVALID_CHAR);
        run_case("no semicolon", "if(x==1)beginp<=1)endelsebeginp<=2;end",
                 0, 0, 0, 1'b0, ERR_MISSING_SEMICOLON);
        run_case("lone =", "if(x=1)beginp<=1;endelsebeginp<=2;end",
                 0, 0, 0, 1'b0, ERR_MISSING_OPERATOR);
        run_case("lone !", "if(x!1)beginp<=1;endelsebeginp<=2;end",
                 0, 0, 0, 1'b0, ERR_MISSING_OPERATOR);
        run_case("digit variable", "if(5==1)beginp<=1;endelsebeginp<=2;end",
                 0, 0, 0, 1'b0, ERR_SYNTAX);

        @(posedge clk);                           // Let the last window report
        $display("Error count: %0d result, %0d status", value_errors, status_errors);
        if (value_errors + status_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/if_else_parser.sv
`timescale 1ns/10ps
`default_nettype none

module if_else_parser (
    input  wire                       clk,
    input  wire                       rst,
    input  wire parser_pkg::char_t    char,
    input  wire                       char_valid,
    input  wire parser_pkg::value_t   x,
    output parser_pkg::value_t        p,
    output logic                      parsing_done,
    output logic                      error_flag,
    output parser_pkg::error_code_t   error_code
);

    parser_pkg::num_status_t num;
    parser_pkg::kw_status_t  kw_status;
    parser_pkg::keyword_t    kw_sel;
    parser_pkg::cond_stmt_t  stmt;
    logic                    num_en;
    logic                    num_clear;
    logic                    kw_en;
    logic                    eval_start;

    number_accum u_num (
        .clk       (clk),
        .rst       (rst),
        .char      (char),
        .num_en    (num_en),
        .num_clear (num_clear),
        .num       (num)
    );

    keyword_matcher u_kw (
        .clk       (clk),
        .rst       (rst),
        .char      (char),
        .kw_en     (kw_en),
        .kw_sel    (kw_sel),
        .kw_status (kw_status)
    );

    stmt_parser_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .char       (char),
        .char_valid (char_valid),
        .num        (num),
        .kw_status  (kw_status),
        .num_en     (num_en),
        .num_clear  (num_clear),
        .kw_en      (kw_en),
        .kw_sel     (kw_sel),
        .stmt       (stmt),
        .eval_start (eval_start),
        .error_flag (error_flag),
        .error_code (error_code)
    );

    // Result stage, one edge after the FSM reaches EVALUATE
    cond_eval u_eval (
        .clk          (clk),
        .rst          (rst),
        .x            (x),
        .stmt         (stmt),
        .eval_start   (eval_start),
        .p            (p),
        .parsing_done (parsing_done)
    );

endmodule

`default_nettype wire

//--- verilog/cond_eval.sv
`timescale 1ns/10ps
`default_nettype none

module cond_eval import parser_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire value_t     x,
    input  wire cond_stmt_t stmt,
    input  wire             eval_start,
    output value_t          p,
    output logic            parsing_done
);

    logic take;                                   // Condition holds so const1 is taken

    // Signed compare of x against the parsed constant
    always_comb begin
        case (stmt.comparator)
            CMP_EQ:  take = (x == stmt.valc);
            CMP_NE:  take = (x != stmt.valc);
            CMP_LT:  take = (x < stmt.valc);
            CMP_GT:  take = (x > stmt.valc);
            CMP_LE:  take = (x <= stmt.valc);
            CMP_GE:  take = (x >= stmt.valc);
            default: take = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            p            <= '0;
            parsing_done <= 1'b0;
        end else if (eval_start) begin
            p            <= take ? stmt.const1 : stmt.const2;
            parsing_done <= 1'b1;
        end
    end

    // eval_start comes once per statement so the result stays put
    a_done_sticky : assert property (
        @(posedge clk) disable iff (rst) parsing_done |=> parsing_done && $stable(p)
    );

endmodule

`default_nettype wire

//--- verilog/stmt_parser_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module stmt_parser_fsm import parser_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire char_t       char,
    input  wire              char_valid,
    input  wire num_status_t num,
    input  wire kw_status_t  kw_status,
    output logic             num_en,
    output logic             num_clear,
    output logic             kw_en,
    output keyword_t         kw_sel,
    output cond_stmt_t       stmt,
    output logic             eval_start,
    output logic             error_flag,
    output error_code_t      error_code
);

    typedef enum logic [3:0] {
        ST_IF,
        ST_OPEN_PAREN,
        ST_COND_VAR,
        ST_OP1,
        ST_OP2,
        ST_VALC,
        ST_BEGIN,
        ST_ASSIGN_VAR,
        ST_ASSIGN_OP,
        ST_CONST,
        ST_END,
        ST_ELSE,
        ST_EVALUATE,
        ST_FINISHED,
        ST_HALT
    } state_t;

    state_t      state;
    state_t      state_n;
    state_t      kw_next;
    error_code_t err_n;
    logic        in_else;                         // Parsing the else branch
    logic        assign_lt;                       // "<" of "<=" already seen
    char_t       first_var;                       // Target of the if branch
    logic        is_letter;
    logic        lt_gt;                           // Single char comparator so far

    assign is_letter = ((char >= "a") && (char <= "z")) || ((char >= "A") && (char <= "Z"));
    assign lt_gt     = (stmt.comparator == CMP_LT) || (stmt.comparator == CMP_GT);

    // Keyword sequencing
    always_comb begin
        case (state)
            ST_BEGIN: kw_sel = KW_BEGIN;
            ST_END:   kw_sel = KW_END;
            ST_ELSE:  kw_sel = KW_ELSE;
            default:  kw_sel = KW_IF;
        endcase
        case (state)
            ST_IF:    kw_next = ST_OPEN_PAREN;
            ST_BEGIN: kw_next = ST_ASSIGN_VAR;
            ST_ELSE:  kw_next = ST_BEGIN;
            default:  kw_next = in_else ? ST_EVALUATE : ST_ELSE;
        endcase
    end

    assign kw_en = char_valid && ((state == ST_IF) || (state == ST_BEGIN) ||
                                  (state == ST_END) || (state == ST_ELSE));

    // The "<" and ">" shortcut lets a digit or sign start the number early
    assign num_en = char_valid && ((state == ST_VALC) || (state == ST_CONST) ||
                                   ((state == ST_OP2) && lt_gt));

    // Clear once the terminator has been seen and the value latched
    assign num_clear = char_valid && !num.absorbed &&
                       ((state == ST_VALC) || (state == ST_CONST));

    assign eval_start = (state == ST_EVALUATE);

    always_comb begin
        state_n = state;
        err_n   = ERR_NONE;
        if (char_valid) begin
            case (state)
                ST_IF, ST_BEGIN, ST_END, ST_ELSE: begin
                    if (kw_status == KW_BAD)
                        err_n = ERR_INVALID_KEYWORD;
                    else if (kw_status == KW_DONE)
                        state_n = kw_next;
                end
                ST_OPEN_PAREN: begin
                    if (char == "(")
                        state_n = ST_COND_VAR;
                    else if (is_letter)
                        err_n = ERR_INVALID_KEYWORD;  // Keyword ran on, e.g. "iff"
                    else
                        err_n = ERR_SYNTAX;
                end
                ST_COND_VAR: begin
                    if (is_letter)
                        state_n = ST_OP1;
                    else
                        err_n = ERR_SYNTAX;
                end
                ST_OP1: begin
                    if ((char == "<") || (char == ">") || (char == "=") || (char == "!"))
                        state_n = ST_OP2;
                    else
                        err_n = ERR_INVALID_CHAR;
                end
                ST_OP2: begin
                    if ((char == "=") || num.absorbed)
                        state_n = ST_VALC;
                    else if (!lt_gt)
                        err_n = ERR_MISSING_OPERATOR; // "=" or "!" alone
                    else
                        err_n = ERR_SYNTAX;
                end
                ST_VALC: begin
                    if (!num.absorbed) begin
                        if (num.started && (char == ")"))
                            state_n = ST_BEGIN;
                        else
                            err_n = ERR_SYNTAX;
                    end
                end
                ST_ASSIGN_VAR: begin
                    if (!is_letter)
                        err_n = ERR_SYNTAX;
                    else if (in_else && (char != first_var))
                        err_n = ERR_VAR_MISMATCH;
                    else
                        state_n = ST_ASSIGN_OP;
                end
                ST_ASSIGN_OP: begin
                    if (char == "=")
                        state_n = ST_CONST;
                    else if ((char != "<") || assign_lt)
                        err_n = ERR_MISSING_OPERATOR;
                end
                ST_CONST: begin
                    if (!num.absorbed) begin
                        if (!num.started)
                            err_n = ERR_SYNTAX;
                        else if (char != ";")
                            err_n = ERR_MISSING_SEMICOLON;
                        else
                            state_n = ST_END;
                    end
                end
                default: ;
            endcase
        end
        if (state == ST_EVALUATE)
            state_n = ST_FINISHED;
        if (err_n != ERR_NONE)
            state_n = ST_HALT;                    // First error wins
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IF;
            error_flag <= 1'b0;
            error_code <= ERR_NONE;
            in_else    <= 1'b0;
            assign_lt  <= 1'b0;
        end else begin
            state <= state_n;
            if (err_n != ERR_NONE) begin
                error_flag <= 1'b1;
                error_code <= err_n;
            end
            if (char_valid && (state == ST_ELSE) && (kw_status == KW_DONE))
                in_else <= 1'b1;
            if (char_valid && (state == ST_ASSIGN_OP))
                assign_lt <= (char == "<");
        end
    end

    // Operands, only read once the statement is complete
    always_ff @(posedge clk) begin
        if (char_valid) begin
            case (state)
                ST_OP1: begin
                    case (char)
                        "<":     stmt.comparator <= CMP_LT;
                        ">":     stmt.comparator <= CMP_GT;
                        "!":     stmt.comparator <= CMP_NE;
                        default: stmt.comparator <= CMP_EQ;
                    endcase
                end
                ST_OP2: begin
                    if ((char == "=") && (stmt.comparator == CMP_LT))
                        stmt.comparator <= CMP_LE;
                    else if ((char == "=") && (stmt.comparator == CMP_GT))
                        stmt.comparator <= CMP_GE;
                end
                ST_VALC: if (!num.absorbed) stmt.valc <= num.value;
                ST_CONST: begin
                    if (!num.absorbed && in_else)
                        stmt.const2 <= num.value;
                    else if (!num.absorbed)
                        stmt.const1 <= num.value;
                end
                ST_ASSIGN_VAR: if (!in_else) first_var <= char;
                default: ;
            endcase
        end
    end

    a_err_consistent : assert property (
        @(posedge clk) disable iff (rst) error_flag == (error_code != ERR_NONE)
    );

endmodule

`default_nettype wire

//--- verilog/keyword_matcher.sv
`timescale 1ns/10ps
`default_nettype none

module keyword_matcher import parser_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire char_t    char,
    input  wire           kw_en,
    input  wire keyword_t kw_sel,
    output kw_status_t    kw_status
);

    logic [2:0]  idx;                             // Position within the keyword
    logic [2:0]  len;
    logic [39:0] word;                            // Up to five letters, right aligned
    logic [5:0]  bit_pos;
    char_t       expected;

    // Keyword table
    always_comb begin
        case (kw_sel)
            KW_IF: begin
                word = "if";
                len  = 3'd2;
            end
            KW_BEGIN: begin
                word = "begin";
                len  = 3'd5;
            end
            KW_END: begin
                word = "end";
                len  = 3'd3;
            end
            default: begin
                word = "else";
                len  = 3'd4;
            end
        endcase
    end

    // First letter lives in the highest used byte
    assign bit_pos  = {len - 3'd1 - idx, 3'b000};
    assign expected = word[bit_pos +: 7];

    always_comb begin
        if (char != expected)
            kw_status = KW_BAD;
        else if (idx == len - 3'd1)
            kw_status = KW_DONE;
        else
            kw_status = KW_MORE;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx <= 3'd0;
        end else if (kw_en) begin
            if (kw_status == KW_MORE)
                idx <= idx + 3'd1;
            else
                idx <= 3'd0;                      // Done or bad, ready for the next word
        end
    end

    // Keyword changes from the FSM only happen with the index back at zero
    a_idx_range : assert property (
        @(posedge clk) disable iff (rst) idx < len
    );

endmodule

`default_nettype wire

//--- verilog/number_accum.sv
`timescale 1ns/10ps
`default_nettype none

module number_accum import parser_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire char_t  char,
    input  wire         num_en,
    input  wire         num_clear,
    output num_status_t num
);

    logic [VALUE_W-1:0] mag;                      // Unsigned magnitude
    logic               neg;
    logic               started;
    logic               is_digit;
    logic               is_minus;
    logic [3:0]         digit;

    assign is_digit = (char >= "0") && (char <= "9");
    assign is_minus = (char == "-") && !started;  // Sign only before any digit
    assign digit    = char[3:0];                  // ASCII digits sit at 0x30

    assign num.absorbed = num_en && (is_digit || is_minus);
    assign num.started  = started;
    assign num.value    = neg ? value_t'(-mag) : value_t'(mag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mag     <= '0;
            neg     <= 1'b0;
            started <= 1'b0;
        end else if (num_clear) begin
            mag     <= '0;
            neg     <= 1'b0;
            started <= 1'b0;
        end else if (num.absorbed) begin
            started <= 1'b1;
            if (is_digit)
                mag <= mag * 10 + VALUE_W'(digit);
            else
                neg <= 1'b1;
        end
    end

    // The FSM owns when characters reach the accumulator
    a_absorb_gated : assert property (
        @(posedge clk) disable iff (rst)
        !num_en && !num_clear |=> $stable(mag) && $stable(neg) && $stable(started)
    );

endmodule

`default_nettype wire

//--- verilog/parser_pkg.sv
`default_nettype none

package parser_pkg;

    // Width of x, p and every parsed constant
    localparam int VALUE_W = 32;

    typedef logic [6:0] char_t;                   // 7-bit ASCII
    typedef logic signed [VALUE_W-1:0] value_t;

    // Comparator codes
    typedef enum logic [2:0] {
        CMP_EQ = 3'b000,
        CMP_NE = 3'b001,
        CMP_LT = 3'b010,
        CMP_GT = 3'b011,
        CMP_LE = 3'b100,
        CMP_GE = 3'b101
    } comparator_t;

    typedef enum logic [3:0] {
        ERR_NONE              = 4'd0,
        ERR_INVALID_KEYWORD   = 4'd1,
        ERR_VAR_MISMATCH      = 4'd2,
        ERR_INVALID_CHAR      = 4'd3,
        ERR_MISSING_SEMICOLON = 4'd4,
        ERR_MISSING_OPERATOR  = 4'd5,
        ERR_SYNTAX            = 4'd6
    } error_code_t;

    // Keywords known to the matcher
    typedef enum logic [1:0] {
        KW_IF,
        KW_BEGIN,
        KW_END,
        KW_ELSE
    } keyword_t;

    typedef enum logic [1:0] {
        KW_MORE,                                  // Matched, more letters to come
        KW_DONE,                                  // Last letter matched
        KW_BAD                                    // Mismatch
    } kw_status_t;

    // Number accumulator status, 34 bits
    typedef struct packed {
        value_t value;                            // Signed value so far
        logic   absorbed;                         // Current char was taken
        logic   started;                          // Digit or sign seen
    } num_status_t;

    // Parsed statement, 99 bits
    typedef struct packed {
        comparator_t comparator;
        value_t      valc;
        value_t      const1;
        value_t      const2;
    } cond_stmt_t;

endpackage

`default_nettype wire
